/* acs/acs_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module acs_unit
(
   input  wire           clk,
   input  wire           rst,
   input  wire           enable,
   input  wire           vit_pkg::sym_t sym,
   output vit_pkg::dec_t dec
);

   logic [vit_pkg::metric_w-1:0]   pm     [vit_pkg::num_states];
   logic [vit_pkg::metric_w-1:0]   pm_new [vit_pkg::num_states];
   logic [vit_pkg::metric_w-1:0]   pm_min;
   logic [vit_pkg::num_states-1:0] decision;
   logic [3:0]                     sym_cnt;
   logic                           last_sym;

   // hamming distance between expected and received pair
   function automatic logic [1:0] branch_metric
   (
      input logic [3:0] taps_in,
      input logic       ra,
      input logic       rb
   );
      logic ea;
      logic eb;
      ea = ^(taps_in & vit_pkg::gen_a);
      eb = ^(taps_in & vit_pkg::gen_b);
      return {1'b0, ea ^ ra} + {1'b0, eb ^ rb};
   endfunction

   // ============================================================
   // add-compare-select, one cell per next state
   // ============================================================
   always_comb
   begin
      logic [2:0]                   p0;
      logic [2:0]                   p1;
      logic [1:0]                   bm0;
      logic [1:0]                   bm1;
      logic [vit_pkg::metric_w-1:0] m0;
      logic [vit_pkg::metric_w-1:0] m1;
      for (int n = 0; n < vit_pkg::num_states; n++)
      begin
         // predecessors differ only in the oldest bit
         p0  = {n[1:0], 1'b0};
         p1  = {n[1:0], 1'b1};
         bm0 = branch_metric({n[2], p0}, sym.bit_a, sym.bit_b);
         bm1 = branch_metric({n[2], p1}, sym.bit_a, sym.bit_b);
         m0  = pm[p0] + {{(vit_pkg::metric_w-2){1'b0}}, bm0};
         m1  = pm[p1] + {{(vit_pkg::metric_w-2){1'b0}}, bm1};
         // tie keeps the lower predecessor
         decision[n] = (m1 < m0);
         pm_new[n]   = (m1 < m0) ? m1 : m0;
      end
   end

   always_comb
   begin
      pm_min = pm_new[0];
      for (int i = 1; i < vit_pkg::num_states; i++)
      begin
         if (pm_new[i] < pm_min)
            pm_min = pm_new[i];
      end
   end

   assign last_sym = (sym_cnt == 4'(vit_pkg::block_len - 1));

   // metrics restart from state 0 after every block
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         for (int i = 0; i < vit_pkg::num_states; i++)
            pm[i] <= (i == 0) ? '0 : vit_pkg::init_metric;
      end
      else if (!enable || (sym.valid && last_sym))
      begin
         for (int i = 0; i < vit_pkg::num_states; i++)
            pm[i] <= (i == 0) ? '0 : vit_pkg::init_metric;
      end
      else if (sym.valid)
      begin
         for (int i = 0; i < vit_pkg::num_states; i++)
            pm[i] <= pm_new[i] - pm_min;
      end
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         sym_cnt <= '0;
         dec     <= '0;
      end
      else if (!enable)
      begin
         sym_cnt <= '0;
         dec     <= '0;
      end
      else
      begin
         dec.valid <= sym.valid;
         if (sym.valid)
         begin
            dec.bits <= decision;
            dec.last <= last_sym;
            sym_cnt  <= last_sym ? 4'd0 : sym_cnt + 4'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* common/vit_pkg.sv */
`default_nettype none

package vit_pkg;

   // ============================================================
   // code constants
   // ============================================================
   localparam int num_states = 8;
   localparam int block_len  = 16;
   localparam int tail_len   = 3;

   // taps ordered {input, s[2], s[1], s[0]}
   localparam logic [3:0] gen_a = 4'o15;
   localparam logic [3:0] gen_b = 4'o17;

   localparam int metric_w = 6;
   // start value for states other than 0
   localparam logic [metric_w-1:0] init_metric = 6'd16;

   // ============================================================
   // register map
   // ============================================================
   localparam logic [3:0] addr_ctrl   = 4'h0;
   localparam logic [3:0] addr_status = 4'h4;
   localparam logic [3:0] addr_sym    = 4'h8;
   localparam logic [3:0] addr_data   = 4'hC;

   typedef enum logic [1:0]
   {
      tb_idle,
      tb_run,
      tb_hold
   } tb_state_t;

   typedef struct packed
   {
      logic valid;
      logic bit_a;
      logic bit_b;
   } sym_t;

   typedef struct packed
   {
      logic                  valid;
      logic                  last;
      logic [num_states-1:0] bits;
   } dec_t;

   typedef struct packed
   {
      logic valid;
      logic dbit;
      logic last;
   } tb_bit_t;

endpackage

`default_nettype wire

/* logic/apb_port.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_port
(
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 psel,
   input  wire                 penable,
   input  wire                 pwrite,
   input  wire [3:0]           paddr,
   input  wire [31:0]          pwdata,
   output logic [31:0]         prdata,
   output logic                pready,
   output logic                pslverr,
   output vit_pkg::sym_t       sym,
   output logic                enable,
   input  wire [1:0]           bank_full,
   input  wire                 block_ready,
   input  wire [15:0]          block_word,
   output logic                block_taken
);

   logic wr_acc;
   logic rd_acc;
   logic sym_refuse;
   logic data_refuse;

   assign wr_acc = psel && penable && pwrite;
   assign rd_acc = psel && penable && !pwrite;

   // no room left when both banks wait for traceback
   assign sym_refuse  = wr_acc && (paddr == vit_pkg::addr_sym) && (bank_full == 2'b11);
   assign data_refuse = rd_acc && (paddr == vit_pkg::addr_data) && !block_ready;

   assign pready  = 1'b1;
   assign pslverr = sym_refuse || data_refuse;

   // symbol pair sits in pwdata[1:0], a in bit 0
   assign sym.valid = wr_acc && (paddr == vit_pkg::addr_sym) && !sym_refuse;
   assign sym.bit_a = pwdata[0];
   assign sym.bit_b = pwdata[1];

   assign block_taken = rd_acc && (paddr == vit_pkg::addr_data) && block_ready;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         enable <= 1'b0;
      else if (wr_acc && (paddr == vit_pkg::addr_ctrl))
         enable <= pwdata[0];
   end

   always_comb
   begin
      case (paddr)
         vit_pkg::addr_ctrl:   prdata = {31'b0, enable};
         vit_pkg::addr_status: prdata = {29'b0, bank_full, block_ready};
         vit_pkg::addr_data:   prdata = block_ready ? {16'b0, block_word} : 32'b0;
         default:              prdata = 32'b0;
      endcase
   end

endmodule

`default_nettype wire

/* logic/out_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module out_assembler
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               enable,
   input  wire vit_pkg::tb_bit_t             tb_bit,
   output logic [vit_pkg::block_len-1:0]     block_word,
   output logic                              block_ready,
   input  wire                               block_taken
);

   // newest bit arrives first, so fill from the top
   logic [3:0] idx;

   always_ff @(posedge clk)
   begin
      if (tb_bit.valid)
         block_word[idx] <= tb_bit.dbit;
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         idx         <= 4'(vit_pkg::block_len - 1);
         block_ready <= 1'b0;
      end
      else if (!enable)
      begin
         idx         <= 4'(vit_pkg::block_len - 1);
         block_ready <= 1'b0;
      end
      else
      begin
         if (tb_bit.valid)
            idx <= tb_bit.last ? 4'(vit_pkg::block_len - 1) : idx - 4'd1;
         if (tb_bit.valid && tb_bit.last)
            block_ready <= 1'b1;
         else if (block_taken)
            block_ready <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* logic/viterbi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module viterbi_top
(
   input  wire         clk,
   input  wire         rst,
   input  wire         psel,
   input  wire         penable,
   input  wire         pwrite,
   input  wire [3:0]   paddr,
   input  wire [31:0]  pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr
);

   vit_pkg::sym_t                  sym;
   vit_pkg::dec_t                  dec;
   vit_pkg::tb_bit_t               tb_bit;
   logic                           enable;
   logic [1:0]                     bank_full;
   logic                           block_ready;
   logic [vit_pkg::block_len-1:0]  block_word;
   logic                           block_taken;
   logic                           rd_bank;
   logic [3:0]                     rd_addr;
   logic [vit_pkg::num_states-1:0] rd_bits;
   logic                           free_bank;

   apb_port i_apb_port
   (
      .clk         (clk),
      .rst         (rst),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .sym         (sym),
      .enable      (enable),
      .bank_full   (bank_full),
      .block_ready (block_ready),
      .block_word  (block_word),
      .block_taken (block_taken)
   );

   acs_unit i_acs_unit
   (
      .clk    (clk),
      .rst    (rst),
      .enable (enable),
      .sym    (sym),
      .dec    (dec)
   );

   survivor_mem i_survivor_mem
   (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .dec       (dec),
      .rd_bank   (rd_bank),
      .rd_addr   (rd_addr),
      .rd_bits   (rd_bits),
      .free_bank (free_bank),
      .bank_full (bank_full)
   );

   // ready of the assembler is the back-pressure
   tbu i_tbu
   (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .bank_full (bank_full),
      .hold      (block_ready),
      .rd_bank   (rd_bank),
      .rd_addr   (rd_addr),
      .rd_bits   (rd_bits),
      .free_bank (free_bank),
      .tb_bit    (tb_bit)
   );

   out_assembler i_out_assembler
   (
      .clk         (clk),
      .rst         (rst),
      .enable      (enable),
      .tb_bit      (tb_bit),
      .block_word  (block_word),
      .block_ready (block_ready),
      .block_taken (block_taken)
   );

endmodule

`default_nettype wire

/* sim.f */
common/vit_pkg.sv
logic/apb_port.sv
acs/acs_unit.sv
survivor/survivor_mem.sv
survivor/tbu.sv
logic/out_assembler.sv
logic/viterbi_top.sv
test/tb_viterbi.sv

/* survivor/survivor_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module survivor_mem
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               enable,
   input  wire vit_pkg::dec_t                dec,
   input  wire                               rd_bank,
   input  wire [3:0]                         rd_addr,
   output logic [vit_pkg::num_states-1:0]    rd_bits,
   input  wire                               free_bank,
   output logic [1:0]                        bank_full
);

   // two banks side by side, bank select is the top address bit
   logic [vit_pkg::num_states-1:0] mem [2*vit_pkg::block_len];
   logic                           wr_bank;
   logic [3:0]                     wr_ptr;
   logic                           wr_ok;

   // a full write bank drops the vector
   assign wr_ok = enable && dec.valid && !bank_full[wr_bank];

   always_ff @(posedge clk)
   begin
      if (wr_ok)
         mem[{wr_bank, wr_ptr}] <= dec.bits;
   end

   assign rd_bits = mem[{rd_bank, rd_addr}];

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         wr_bank   <= 1'b0;
         wr_ptr    <= '0;
         bank_full <= '0;
      end
      else if (!enable)
      begin
         wr_bank   <= 1'b0;
         wr_ptr    <= '0;
         bank_full <= '0;
      end
      else
      begin
         if (free_bank)
            bank_full[rd_bank] <= 1'b0;
         if (wr_ok)
         begin
            if (dec.last)
            begin
               wr_ptr             <= '0;
               wr_bank            <= !wr_bank;
               bank_full[wr_bank] <= 1'b1;
            end
            else
               wr_ptr <= wr_ptr + 4'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* survivor/tbu.sv */
`timescale 1ns/1ps
`default_nettype none

module tbu
(
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            enable,
   input  wire [1:0]                      bank_full,
   input  wire                            hold,
   output logic                           rd_bank,
   output logic [3:0]                     rd_addr,
   input  wire [vit_pkg::num_states-1:0]  rd_bits,
   output logic                           free_bank,
   output vit_pkg::tb_bit_t               tb_bit
);

   vit_pkg::tb_state_t state;
   // trellis state being traced
   logic [2:0]         cur_st;

   // frees the bank on the oldest bit, before rd_bank toggles
   assign free_bank = (state == vit_pkg::tb_run) && !hold && (rd_addr == 4'd0);

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state   <= vit_pkg::tb_idle;
         rd_bank <= 1'b0;
         rd_addr <= '0;
         cur_st  <= '0;
         tb_bit  <= '0;
      end
      else if (!enable)
      begin
         state   <= vit_pkg::tb_idle;
         rd_bank <= 1'b0;
         rd_addr <= '0;
         cur_st  <= '0;
         tb_bit  <= '0;
      end
      else
      begin
         tb_bit.valid <= 1'b0;
         case (state)
            vit_pkg::tb_idle:
            begin
               // tail bits force the end state to 0
               if (bank_full[rd_bank])
               begin
                  state   <= vit_pkg::tb_run;
                  rd_addr <= 4'(vit_pkg::block_len - 1);
                  cur_st  <= '0;
               end
            end

            vit_pkg::tb_run:
            begin
               if (hold)
                  state <= vit_pkg::tb_hold;
               else
               begin
                  tb_bit.valid <= 1'b1;
                  tb_bit.dbit  <= cur_st[2];
                  tb_bit.last  <= (rd_addr == 4'd0);
                  // step back to the stored predecessor
                  cur_st       <= {cur_st[1:0], rd_bits[cur_st]};
                  rd_addr      <= rd_addr - 4'd1;
                  if (rd_addr == 4'd0)
                  begin
                     rd_bank <= !rd_bank;
                     state   <= vit_pkg::tb_idle;
                  end
               end
            end

            vit_pkg::tb_hold:
            begin
               if (!hold)
                  state <= vit_pkg::tb_run;
            end

            default:
               state <= vit_pkg::tb_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* test/tb_viterbi.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_viterbi;

   // taps ordered {input, s[2], s[1], s[0]}, 15 and 17 octal
   localparam logic [3:0] poly_a = 4'b1101;
   localparam logic [3:0] poly_b = 4'b1111;

   // about thirteen blocks of some 75 cycles each
   localparam int num_blocks   = 13;
   localparam int block_cycles = 100;
   localparam int cycle_limit  = num_blocks * block_cycles + 200;

   logic        clk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [3:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   int          err_cnt;
   int          check_cnt;
   int          test_pass;
   int          test_fail;
   int          err_at_start;
   logic [31:0] lcg_state;

   viterbi_top i_viterbi_top
   (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   always #50 clk = ~clk;

   // ============================================================
   // bus protocol checks
   // ============================================================
   pready_high: assert property (@(posedge clk) disable iff (!rst) pready)
   else
   begin
      $display("Mismatch at %0t: pready low", $time);
      err_cnt++;
   end

   slverr_in_enable: assert property (@(posedge clk) disable iff (!rst)
                                      pslverr |-> (psel && penable))
   else
   begin
      $display("Mismatch at %0t: pslverr outside an enable phase", $time);
      err_cnt++;
   end

   function automatic logic [31:0] rand_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // 13 data bits, then the zero tail
   function automatic logic [15:0] make_word();
      logic [31:0] r;
      r = rand_next();
      return {3'b000, r[28:16]};
   endfunction

   // pair k sits in bits 2k+1:2k, a in the low bit
   function automatic logic [31:0] encode_block(input logic [15:0] word);
      logic [2:0]  st;
      logic [3:0]  taps;
      logic [31:0] syms;
      st   = 3'b000;
      syms = '0;
      for (int k = 0; k < 16; k++)
      begin
         taps          = {word[k], st};
         syms[2*k]     = ^(taps & poly_a);
         syms[2*k + 1] = ^(taps & poly_b);
         st            = {word[k], st[2:1]};
      end
      return syms;
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      check_cnt++;
      assert (got === exp)
      else
      begin
         $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      #10;
      err = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      #10;
      data = prdata;
      err  = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // flip < 0 sends the pairs unchanged
   task automatic send_block(input logic [31:0] syms, input int flip, input int count);
      logic [31:0] rx;
      logic        err;
      rx = syms;
      if (flip >= 0)
         rx[flip] = ~rx[flip];
      for (int k = 0; k < count; k++)
      begin
         apb_write(vit_pkg::addr_sym, {30'b0, rx[2*k + 1], rx[2*k]}, err);
         check("symbol write pslverr", err, 32'd0);
      end
   endtask

   task automatic wait_status(input logic [31:0] mask, input logic [31:0] value);
      logic [31:0] st;
      logic        err;
      apb_read(vit_pkg::addr_status, st, err);
      while ((st & mask) != value)
         apb_read(vit_pkg::addr_status, st, err);
   endtask

   task automatic read_word(input logic [15:0] exp, input string what);
      logic [31:0] got;
      logic        err;
      apb_read(vit_pkg::addr_data, got, err);
      check({what, " pslverr"}, err, 32'd0);
      check(what, got, {16'b0, exp});
   endtask

   task automatic decode_block(input logic [15:0] word, input int flip);
      send_block(encode_block(word), flip, 16);
      wait_status(32'h1, 32'h1);
      read_word(word, "decoded word");
   endtask

   task automatic end_test(input string name);
      if (err_cnt == err_at_start)
      begin
         test_pass++;
         $display("test %s: ok", name);
      end
      else
      begin
         test_fail++;
         $display("test %s: failed with %0d errors", name, err_cnt - err_at_start);
      end
      err_at_start = err_cnt;
   endtask

   // run limit
   initial
   begin
      int cycles;
      cycles = 0;
      while (cycles < cycle_limit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      logic [15:0] w0;
      logic [15:0] w1;
      logic [15:0] w2;
      logic [31:0] rd;
      logic        err;
      int          pos;
      clk          = 1'b0;
      rst          = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      err_cnt      = 0;
      check_cnt    = 0;
      test_pass    = 0;
      test_fail    = 0;
      err_at_start = 0;
      lcg_state    = 32'd11458;
      repeat (5) @(negedge clk);
      rst = 1'b1;

      apb_read(vit_pkg::addr_status, rd, err);
      check("status after reset", rd, 32'd0);
      check("status read pslverr", err, 32'd0);
      apb_read(vit_pkg::addr_ctrl, rd, err);
      check("ctrl after reset", rd, 32'd0);
      check("ctrl read pslverr", err, 32'd0);
      apb_write(vit_pkg::addr_ctrl, 32'd1, err);
      check("ctrl write pslverr", err, 32'd0);
      apb_read(vit_pkg::addr_ctrl, rd, err);
      check("ctrl enable", rd, 32'd1);
      end_test("reset state");

      repeat (3)
      begin
         w0 = make_word();
         decode_block(w0, -1);
      end
      end_test("clean blocks");

      repeat (3)
      begin
         w0  = make_word();
         pos = int'(rand_next() >> 27);
         decode_block(w0, pos);
      end
      end_test("error correction");

      // the first bank frees once traced, so a third block fills it again
      w0 = make_word();
      w1 = make_word();
      w2 = make_word();
      send_block(encode_block(w0), -1, 16);
      send_block(encode_block(w1), -1, 16);
      send_block(encode_block(w2), -1, 16);
      wait_status(32'h7, 32'h7);
      apb_read(vit_pkg::addr_status, rd, err);
      check("status both banks full", rd, 32'h7);
      apb_write(vit_pkg::addr_sym, 32'd0, err);
      check("symbol write with both banks full", err, 32'd1);
      read_word(w0, "first word");
      wait_status(32'h1, 32'h1);
      read_word(w1, "second word");
      wait_status(32'h1, 32'h1);
      read_word(w2, "third word");
      end_test("ping-pong");

      apb_read(vit_pkg::addr_status, rd, err);
      check("status idle", rd, 32'd0);
      apb_read(vit_pkg::addr_data, rd, err);
      check("data read while empty pslverr", err, 32'd1);
      w0 = make_word();
      decode_block(w0, -1);
      apb_read(vit_pkg::addr_status, rd, err);
      check("ready cleared by data read", rd, 32'd0);
      end_test("empty read");

      // a finished word is left unread while the next block is half sent
      w0 = make_word();
      send_block(encode_block(w0), -1, 16);
      wait_status(32'h1, 32'h1);
      w1 = make_word();
      send_block(encode_block(w1), -1, 7);
      apb_read(vit_pkg::addr_status, rd, err);
      check("status before enable clear", rd, 32'h1);
      apb_write(vit_pkg::addr_ctrl, 32'd0, err);
      check("ctrl clear pslverr", err, 32'd0);
      apb_read(vit_pkg::addr_status, rd, err);
      check("status after enable clear", rd, 32'd0);
      apb_write(vit_pkg::addr_ctrl, 32'd1, err);
      w2 = make_word();
      decode_block(w2, -1);
      end_test("enable clear");

      $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
               test_pass, test_fail, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire
